// ==== obj_dma_pkg.sv ====
// shared address map, phase strobes, copier state and dma bus types for the sprite dma block
package obj_dma_pkg;

    // words moved per frame
    localparam int obj_words = 64;

    // byte address map seen from the host
    localparam logic [11:0] wram_base = 12'h000; // work ram table
    localparam logic [11:0] ctrl_addr = 12'h100; // bit 0 dm10
    localparam logic [11:0] stat_addr = 12'h104; // busy, state, frame count
    localparam logic [11:0] oram_base = 12'h200; // object ram, read only

    // video phase strobes, all active low like the board
    typedef struct packed {
        logic vb_n;  // vertical blank
        logic ai_n;  // first phase, even pixels
        logic bi_n;  // second phase, odd pixels
        logic hbd_n; // horizontal blank delayed
    } phase_t;

    // copier sequencer states
    // encoding is visible in status bits 2..1
    typedef enum logic [1:0] {
        idle       = 2'd0,
        wait_grant = 2'd1,
        copy       = 2'd2,
        done       = 2'd3
    } copier_state_e;

    // copier side of the ram ports
    typedef struct packed {
        logic [5:0]  rd_addr; // work ram word
        logic [5:0]  wr_addr; // object ram word
        logic        wr_en;
        logic [31:0] wr_data;
    } dma_bus_t;

endpackage

// ==== video_timing.sv ====
// free running pixel and line counters that decode blanking and the two phase strobes
`timescale 1ns/1ps

module video_timing #(
    parameter int H_TOTAL = 384, // pixels per line, even
    parameter int V_TOTAL = 264, // lines per frame
    parameter int H_BLANK = 128, // blanked pixels at end of line
    parameter int V_BLANK = 40   // blanked lines at end of frame
) (
    input  logic                clk,
    input  logic                reset,
    output obj_dma_pkg::phase_t phase
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    logic [HW-1:0] hcnt;
    logic [VW-1:0] vcnt;
    logic          hblank;
    logic          vblank;
    logic [1:0]    hb_dly; // hblank delay line

    // pixel and line counters
    always_ff @(posedge clk) begin
        if (reset) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == HW'(H_TOTAL - 1)) begin
            hcnt <= '0;
            if (vcnt == VW'(V_TOTAL - 1))
                vcnt <= '0; // wrap frame
            else
                vcnt <= vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    assign hblank = hcnt >= HW'(H_TOTAL - H_BLANK);
    assign vblank = vcnt >= VW'(V_TOTAL - V_BLANK);

    // delayed hblank, two pixels late as on the board
    always_ff @(posedge clk) begin
        if (reset)
            hb_dly <= 2'b00;
        else
            hb_dly <= {hb_dly[0], hblank};
    end

    // registered strobes so the edge detectors see clean levels
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '1; // everything inactive
        end else begin
            phase.vb_n  <= !vblank;
            phase.ai_n  <= hcnt[0];  // low on even pixels
            phase.bi_n  <= !hcnt[0]; // low on odd pixels
            phase.hbd_n <= !hb_dly[1];
        end
    end

endmodule

// ==== bus_req_ctrl.sv ====
// bus request and pacing latches, edge detected on the video strobes, drive busrq_n and rohvck
`timescale 1ns/1ps

module bus_req_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  obj_dma_pkg::phase_t phase,
    input  logic                dm10,
    input  logic                busak,
    output logic                busrq_n,
    output logic                rohvck,
    output logic                mr_n
);

    logic last_vb_n, last_ai_n, last_bi_n, last_dm10, last_h1;
    logic vb_fall, ai_fall, bi_rise, dm10_fall, h1_rise;
    logic h1;       // half rate phase
    logic grant_q;  // busak seen on bi
    logic pace;     // first pacing latch
    logic pace2;    // second pacing latch
    logic pace_din;
    logic pace_clr;

    // previous input levels for the edge detectors
    always_ff @(posedge clk) begin
        if (reset) begin
            last_vb_n <= 1'b1;
            last_ai_n <= 1'b1;
            last_bi_n <= 1'b1;
            last_dm10 <= 1'b0;
            last_h1   <= 1'b0;
        end else begin
            last_vb_n <= phase.vb_n;
            last_ai_n <= phase.ai_n;
            last_bi_n <= phase.bi_n;
            last_dm10 <= dm10;
            last_h1   <= h1;
        end
    end

    assign vb_fall   = !phase.vb_n && last_vb_n;
    assign ai_fall   = !phase.ai_n && last_ai_n;
    assign bi_rise   = phase.bi_n && !last_bi_n;
    assign dm10_fall = !dm10 && last_dm10; // copier finished or host cancelled
    assign h1_rise   = h1 && !last_h1;

    // request latch
    always_ff @(posedge clk) begin
        if (reset)
            busrq_n <= 1'b1;
        else if (dm10_fall)
            busrq_n <= 1'b1;
        else if (vb_fall && dm10)
            busrq_n <= 1'b0; // only when a table is waiting
    end

    // h1 and grant latches
    always_ff @(posedge clk) begin
        if (reset) begin
            h1      <= 1'b0;
            grant_q <= 1'b0;
        end else begin
            if (ai_fall)
                h1 <= !h1; // flips every ai strobe
            if (bi_rise)
                grant_q <= busak;
        end
    end

    // no pacing in hblank
    assign pace_din = grant_q && phase.hbd_n;
    assign pace_clr = busrq_n && !grant_q; // idle bus

    // cascaded pacing latches
    always_ff @(posedge clk) begin
        if (reset || pace_clr) begin
            pace  <= 1'b0;
            pace2 <= 1'b0;
        end else begin
            if (h1_rise)
                pace <= pace_din;
            if (ai_fall)
                pace2 <= pace && pace_din;
        end
    end

    assign rohvck = pace2 && h1 && !phase.bi_n; // one pulse per four clocks
    assign mr_n   = !(grant_q || pace);         // cpu ram cycles off while paced

endmodule

// ==== obj_copier.sv ====
// sequencer that moves the sprite table from work ram to object ram on each pacing strobe
`timescale 1ns/1ps

module obj_copier #(
    parameter int OBJ_WORDS = 64 // at most 64, address is 6 bits
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       busak,
    input  logic                       rohvck,
    output obj_dma_pkg::dma_bus_t      dma,
    input  logic [31:0]                rd_data,
    output obj_dma_pkg::copier_state_e state,
    output logic                       copy_done
);

    localparam logic [5:0] LAST = 6'(OBJ_WORDS - 1);

    logic       last_busak;
    logic       last_rohvck;
    logic       grant_rise;
    logic       pace_rise;
    logic [5:0] rd_ptr;     // next word to read
    logic [5:0] wr_ptr;     // word in flight
    logic       rd_pend;    // read data arrives this cycle
    logic       issued_all; // final read already sent

    always_ff @(posedge clk) begin
        if (reset) begin
            last_busak  <= 1'b0;
            last_rohvck <= 1'b0;
        end else begin
            last_busak  <= busak;
            last_rohvck <= rohvck;
        end
    end

    assign grant_rise = busak && !last_busak;
    assign pace_rise  = rohvck && !last_rohvck;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= obj_dma_pkg::idle;
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            rd_pend    <= 1'b0;
            issued_all <= 1'b0;
        end else begin
            rd_pend <= 1'b0; // single cycle unless a read issues
            case (state)
                obj_dma_pkg::idle: begin
                    if (grant_rise) begin
                        state      <= obj_dma_pkg::wait_grant;
                        rd_ptr     <= '0;
                        issued_all <= 1'b0;
                    end
                end
                obj_dma_pkg::wait_grant: begin
                    // grant must still be there one cycle on
                    if (busak)
                        state <= obj_dma_pkg::copy;
                    else
                        state <= obj_dma_pkg::idle;
                end
                obj_dma_pkg::copy: begin
                    if (!busak) begin
                        state <= obj_dma_pkg::idle; // bus taken back, abandon
                    end else begin
                        if (pace_rise && !issued_all) begin
                            rd_pend <= 1'b1;
                            wr_ptr  <= rd_ptr;
                            rd_ptr  <= rd_ptr + 1'b1;
                            if (rd_ptr == LAST)
                                issued_all <= 1'b1;
                        end
                        if (rd_pend && wr_ptr == LAST)
                            state <= obj_dma_pkg::done; // last write goes out now
                    end
                end
                obj_dma_pkg::done: state <= obj_dma_pkg::idle;
                default:           state <= obj_dma_pkg::idle;
            endcase
        end
    end

    // ram side, write trails the read by one cycle
    assign dma.rd_addr = rd_ptr;
    assign dma.wr_addr = wr_ptr;
    assign dma.wr_en   = rd_pend && busak && (state == obj_dma_pkg::copy);
    assign dma.wr_data = rd_data;

    assign copy_done = state == obj_dma_pkg::done;

endmodule

// ==== cpu_axil_port.sv ====
// axi4-lite slave holding work ram, object ram and the dma control and status registers
`timescale 1ns/1ps

module cpu_axil_port #(
    parameter int OBJ_WORDS = 64
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [11:0]                awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [11:0]                araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic                       busrq_n,
    input  logic                       mr_n,
    input  obj_dma_pkg::dma_bus_t      dma,
    output logic [31:0]                rd_data,
    input  obj_dma_pkg::copier_state_e state,
    input  logic                       copy_done,
    output logic                       dm10,
    output logic                       busak
);

    logic [31:0] wram [OBJ_WORDS];
    logic [31:0] oram [OBJ_WORDS];
    logic [11:0] w_addr_q, r_addr_q;
    logic [31:0] w_data_q;
    logic        w_pend, r_pend; // accepted, ram cycle next edge
    logic        aw_fire, ar_fire;
    logic        ram_free;
    logic        ram_pend;
    logic [7:0]  frame_cnt;
    logic        busy;

    function automatic logic in_range(input logic [11:0] a, input logic [11:0] base);
        return (a >= base) && (a < base + 12'(OBJ_WORDS * 4));
    endfunction

    function automatic logic is_ram(input logic [11:0] a);
        return in_range(a, obj_dma_pkg::wram_base) || in_range(a, obj_dma_pkg::oram_base);
    endfunction

    function automatic logic [5:0] word_idx(input logic [11:0] a, input logic [11:0] base);
        logic [11:0] off;
        off = a - base;
        return off[7:2];
    endfunction

    // ram held off while the copier owns it
    assign ram_free = !busak && mr_n;
    assign aw_fire  = awvalid && wvalid && !w_pend && !bvalid && (ram_free || !is_ram(awaddr));
    assign ar_fire  = arvalid && !r_pend && !rvalid && (ram_free || !is_ram(araddr));
    assign awready  = aw_fire;
    assign wready   = aw_fire; // address and data taken together
    assign arready  = ar_fire;
    assign bresp    = 2'b00;   // always okay
    assign rresp    = 2'b00;

    assign ram_pend = (aw_fire && is_ram(awaddr)) || (w_pend && is_ram(w_addr_q))
                    || (ar_fire && is_ram(araddr)) || (r_pend && is_ram(r_addr_q));

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            w_addr_q <= awaddr;
            w_data_q <= wdata;
        end
        if (ar_fire)
            r_addr_q <= araddr;
    end

    // handshake flags
    always_ff @(posedge clk) begin
        if (reset) begin
            w_pend <= 1'b0;
            r_pend <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            w_pend <= aw_fire;
            r_pend <= ar_fire;
            if (w_pend)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (r_pend)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // ram ports, copier or host
    always_ff @(posedge clk) begin
        if (busak) begin
            rd_data <= wram[dma.rd_addr];
            if (dma.wr_en)
                oram[dma.wr_addr] <= dma.wr_data;
        end else if (w_pend && in_range(w_addr_q, obj_dma_pkg::wram_base)) begin
            wram[word_idx(w_addr_q, obj_dma_pkg::wram_base)] <= w_data_q;
        end
    end

    assign busy = dm10 || (state != obj_dma_pkg::idle);

    // read mux
    always_ff @(posedge clk) begin
        if (r_pend) begin
            if (in_range(r_addr_q, obj_dma_pkg::wram_base))
                rdata <= wram[word_idx(r_addr_q, obj_dma_pkg::wram_base)];
            else if (in_range(r_addr_q, obj_dma_pkg::oram_base))
                rdata <= oram[word_idx(r_addr_q, obj_dma_pkg::oram_base)];
            else if (r_addr_q == obj_dma_pkg::ctrl_addr)
                rdata <= {31'd0, dm10};
            else if (r_addr_q == obj_dma_pkg::stat_addr)
                rdata <= {16'd0, frame_cnt, 5'd0, state, busy};
            else
                rdata <= '0; // unmapped
        end
    end

    // control, frame count, grant
    always_ff @(posedge clk) begin
        if (reset) begin
            dm10      <= 1'b0;
            frame_cnt <= '0;
            busak     <= 1'b0;
        end else begin
            if (w_pend && w_addr_q == obj_dma_pkg::ctrl_addr)
                dm10 <= w_data_q[0]; // host write wins
            else if (copy_done)
                dm10 <= 1'b0;
            if (copy_done)
                frame_cnt <= frame_cnt + 8'd1;
            if (busrq_n)
                busak <= 1'b0;
            else if (!ram_pend)
                busak <= 1'b1; // grant once host ram traffic drains
        end
    end

endmodule

// ==== obj_dma_top.sv ====
// top level of the sprite dma block, wires the video timing, bus control, copier and host port
`timescale 1ns/1ps

module obj_dma_top #(
    parameter int OBJ_WORDS = obj_dma_pkg::obj_words,
    parameter int H_TOTAL   = 384,
    parameter int V_TOTAL   = 264,
    parameter int H_BLANK   = 128,
    parameter int V_BLANK   = 40
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [11:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    obj_dma_pkg::phase_t        phase;
    obj_dma_pkg::dma_bus_t      dma;
    obj_dma_pkg::copier_state_e state;
    logic                       dm10;
    logic                       busak;
    logic                       busrq_n;
    logic                       rohvck;
    logic                       mr_n;
    logic                       copy_done;
    logic [31:0]                rd_data;

    video_timing #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL),
        .H_BLANK (H_BLANK),
        .V_BLANK (V_BLANK)
    ) u_video (
        .clk   (clk),
        .reset (reset),
        .phase (phase)
    );

    bus_req_ctrl u_busreq (
        .clk     (clk),
        .reset   (reset),
        .phase   (phase),
        .dm10    (dm10),
        .busak   (busak),
        .busrq_n (busrq_n),
        .rohvck  (rohvck),
        .mr_n    (mr_n)
    );

    obj_copier #(
        .OBJ_WORDS (OBJ_WORDS)
    ) u_copier (
        .clk       (clk),
        .reset     (reset),
        .busak     (busak),
        .rohvck    (rohvck),
        .dma       (dma),
        .rd_data   (rd_data),
        .state     (state),
        .copy_done (copy_done)
    );

    cpu_axil_port #(
        .OBJ_WORDS (OBJ_WORDS)
    ) u_port (
        .clk       (clk),
        .reset     (reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .busrq_n   (busrq_n),
        .mr_n      (mr_n),
        .dma       (dma),
        .rd_data   (rd_data),
        .state     (state),
        .copy_done (copy_done),
        .dm10      (dm10),
        .busak     (busak)
    );

endmodule

// ==== tb_obj_dma.sv ====
// directed testbench for the sprite dma top level, drives axi4-lite and checks the ram copies
`timescale 1ns/1ps

module tb_obj_dma;

    localparam int OBJ_WORDS    = obj_dma_pkg::obj_words;
    localparam int H_TOTAL      = 64;
    localparam int V_TOTAL      = 32;
    localparam int H_BLANK      = 16;
    localparam int V_BLANK      = 8;
    localparam int CLK_NS       = 40;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL; // 2048 clocks per frame
    localparam int NUM_TESTS    = 5;
    localparam int TIMEOUT_NS   = (16 + NUM_TESTS * 10 * FRAME_CYCLES) * CLK_NS;
    localparam int LATE_IDX     = 17; // word rewritten during the copy

    logic        clk;
    logic        reset;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [31:0] seed;
    logic [31:0] table_q [OBJ_WORDS]; // last table the host put in work ram
    logic [7:0]  copies;              // expected finished copies
    int          write_stalls;        // cycles the last write waited for awready
    int          err_test;
    int          err_total;
    int          check_total;
    string       cur_test;

    obj_dma_top #(
        .OBJ_WORDS (OBJ_WORDS),
        .H_TOTAL   (H_TOTAL),
        .V_TOTAL   (V_TOTAL),
        .H_BLANK   (H_BLANK),
        .V_BLANK   (V_BLANK)
    ) DUT (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // watchdog, ten frames per test
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // status layout: busy bit 0, state bits 2..1, count bits 15..8
    function automatic logic [31:0] status_word(input logic [7:0] cnt,
                                                input obj_dma_pkg::copier_state_e st,
                                                input logic busy);
        logic [31:0] s;
        s       = '0;
        s[0]    = busy;
        s[2:1]  = st;
        s[15:8] = cnt;
        return s;
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_total++;
        if (act !== exp) begin
            err_test++;
            $display("ERROR %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_state(input string what, input obj_dma_pkg::copier_state_e exp,
                               input obj_dma_pkg::copier_state_e act);
        check_total++;
        if (act !== exp) begin
            err_test++;
            $display("ERROR %s: %s expected %s actual %s", cur_test, what, exp.name(), act.name());
        end
    endtask

    task automatic note_failure(input string msg);
        err_test++;
        $display("%s: %s", cur_test, msg);
    endtask

    // all bus tasks start and end 2 ns after a rising edge
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
        write_stalls = 0;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) begin // back-pressure while the copier has the ram
            write_stalls++;
            @(negedge clk);
        end
        @(posedge clk); // handshake
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        if (bresp !== 2'b00)
            note_failure($sformatf("write to 0x%03h did not answer OKAY", addr));
        @(posedge clk);
        #2;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        data = rdata; // stable mid cycle
        if (rresp !== 2'b00)
            note_failure($sformatf("read from 0x%03h did not answer OKAY", addr));
        @(posedge clk);
        #2;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_test = 0;
    endtask

    task automatic finish_test();
        $display("test %s finished, %0d errors", cur_test, err_test);
        err_total += err_test;
    endtask

    // new lcg table into work ram and the local copy
    task automatic fill_table();
        for (int i = 0; i < OBJ_WORDS; i++) begin
            seed       = lcg_step(seed);
            table_q[i] = seed;
            axil_write(obj_dma_pkg::wram_base + 12'(i * 4), seed);
        end
    endtask

    task automatic check_oram();
        logic [31:0] d;
        for (int i = 0; i < OBJ_WORDS; i++) begin
            axil_read(obj_dma_pkg::oram_base + 12'(i * 4), d);
            check_word($sformatf("object ram word %0d", i), table_q[i], d);
        end
    endtask

    task automatic wait_count(input logic [7:0] target);
        logic [31:0] d;
        axil_read(obj_dma_pkg::stat_addr, d);
        while (d[15:8] != target)
            axil_read(obj_dma_pkg::stat_addr, d); // poll until the copy lands
    endtask

    task automatic wait_state(input obj_dma_pkg::copier_state_e target);
        logic [31:0] d;
        axil_read(obj_dma_pkg::stat_addr, d);
        while (obj_dma_pkg::copier_state_e'(d[2:1]) != target)
            axil_read(obj_dma_pkg::stat_addr, d);
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        start_test("reset_state");
        axil_read(obj_dma_pkg::stat_addr, d);
        check_word("status", status_word(8'd0, obj_dma_pkg::idle, 1'b0), d);
        check_state("copier state", obj_dma_pkg::idle, obj_dma_pkg::copier_state_e'(d[2:1]));
        axil_read(obj_dma_pkg::ctrl_addr, d);
        check_word("control", 32'd0, d);
        for (int i = 0; i < OBJ_WORDS; i++)
            table_q[i] = '0; // object ram starts clear
        check_oram();
        finish_test();
    endtask

    task automatic test_wram_readback();
        logic [31:0] d;
        start_test("wram_readback");
        fill_table();
        for (int i = 0; i < OBJ_WORDS; i++) begin
            axil_read(obj_dma_pkg::wram_base + 12'(i * 4), d);
            check_word($sformatf("work ram word %0d", i), table_q[i], d);
        end
        finish_test();
    endtask

    task automatic test_single_copy();
        logic [31:0] d;
        start_test("single_copy");
        axil_write(obj_dma_pkg::ctrl_addr, 32'h1); // dm10
        wait_count(copies + 8'd1);
        copies = copies + 8'd1;
        axil_read(obj_dma_pkg::stat_addr, d);
        check_word("status after copy", status_word(copies, obj_dma_pkg::idle, 1'b0), d);
        check_state("copier state", obj_dma_pkg::idle, obj_dma_pkg::copier_state_e'(d[2:1]));
        axil_read(obj_dma_pkg::ctrl_addr, d);
        check_word("control after copy", 32'd0, d); // request cleared by the copier
        check_oram();
        finish_test();
    endtask

    task automatic test_write_during_copy();
        logic [31:0] d;
        logic [31:0] late;
        start_test("write_during_copy");
        fill_table();
        axil_write(obj_dma_pkg::ctrl_addr, 32'h1);
        wait_state(obj_dma_pkg::copy); // bus now granted
        seed = lcg_step(seed);
        late = seed;
        axil_write(obj_dma_pkg::wram_base + 12'(LATE_IDX * 4), late);
        if (write_stalls == 0)
            note_failure("work ram write during the copy was taken without back-pressure");
        copies = copies + 8'd1;
        axil_read(obj_dma_pkg::stat_addr, d);
        check_word("status after copy", status_word(copies, obj_dma_pkg::idle, 1'b0), d);
        check_oram(); // copy holds the table from before the write
        axil_read(obj_dma_pkg::wram_base + 12'(LATE_IDX * 4), d);
        check_word("work ram word written late", late, d);
        table_q[LATE_IDX] = late;
        finish_test();
    endtask

    task automatic test_two_frames();
        logic [31:0] d;
        logic [7:0]  first;
        start_test("two_frames");
        first = copies;
        for (int n = 0; n < 2; n++) begin
            fill_table(); // second pass rewrites the table
            axil_write(obj_dma_pkg::ctrl_addr, 32'h1);
            wait_count(copies + 8'd1);
            copies = copies + 8'd1;
            check_oram();
        end
        axil_read(obj_dma_pkg::stat_addr, d);
        check_word("status after two copies",
                   status_word(first + 8'd2, obj_dma_pkg::idle, 1'b0), d);
        finish_test();
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b1; // responses always taken
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b1;
        seed        = 32'he16d80c7;
        copies      = '0;
        err_total   = 0;
        check_total = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_state();
        test_wram_readback();
        test_single_copy();
        test_write_during_copy();
        test_two_frames();

        $display("tests run %0d, checks %0d, errors %0d", NUM_TESTS, check_total, err_total);
        if (err_total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
obj_dma_pkg.sv
video_timing.sv
bus_req_ctrl.sv
obj_copier.sv
cpu_axil_port.sv
obj_dma_top.sv
tb_obj_dma.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the sprite dma testbench with verilator, runs it and grades the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps --x-initial 0 -f verilog.f \
    --top-module tb_obj_dma -o sim_tb_obj_dma > build.log 2>&1 \
    && ./obj_dir/sim_tb_obj_dma > sim.log 2>&1 \
    || { cat build.log; cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log \
    && { echo "simulation reported a failure"; exit 1; } \
    || { echo "simulation clean"; exit 0; }
